// File: source/dcache_pkg.sv
package dcache_pkg;

    // cpu side word and address widths
    localparam int DATA_WIDTH = 32;
    localparam int DATA_BYTES = DATA_WIDTH / 8;
    localparam int ALIGN_BITS = $clog2(DATA_BYTES);
    localparam int ADDR_WIDTH = 32;

    // one data word on dbus and cbus
    typedef logic [DATA_WIDTH-1:0] word_t;

    // byte write enables, bit i covers byte i of the word
    typedef logic [DATA_BYTES-1:0] strobe_t;

    // byte address, split by each module into tag/index/offset/align
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // miss engine states
    // READ fetches the new line, WRITE flushes a dirty victim
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2
    } refill_state_t;

endpackage

// File: source/refill_if.sv
`timescale 1ns/1ps

interface refill_if #(
    parameter int WAY_BITS    = 2,
    parameter int INDEX_BITS  = 2,
    parameter int OFFSET_BITS = 2
);
    import dcache_pkg::*;

    localparam int TAG_BITS = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

    // miss request from lookup
    logic                      start;
    addr_t                     miss_addr;
    logic [WAY_BITS-1:0]       victim_way;
    logic [TAG_BITS-1:0]       victim_tag;
    logic                      victim_dirty;

    // progress of the line in flight
    logic                      busy;
    logic                      avail;
    logic [TAG_BITS-1:0]       cur_tag;
    logic [INDEX_BITS-1:0]     cur_index;
    logic [2**OFFSET_BITS-1:0] word_ready;

    modport lookup (
        output start, miss_addr, victim_way, victim_tag, victim_dirty,
        input  busy, avail, cur_tag, cur_index, word_ready
    );

    modport refill (
        input  start, miss_addr, victim_way, victim_tag, victim_dirty,
        output busy, avail, cur_tag, cur_index, word_ready
    );
endinterface

// File: source/set_ram.sv
`timescale 1ns/1ps

module set_ram #(
    parameter int  INDEX_BITS = 2,
    parameter type payload_t  = logic
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [INDEX_BITS-1:0] index,
    input  payload_t              wdata,
    output payload_t              rdata
);
    localparam int NUM_SETS = 2**INDEX_BITS;

    payload_t mem [NUM_SETS];

    // lookup reads the selected set in the request cycle
    assign rdata = mem[index];

    // the set is rewritten each cycle, unchanged when nothing happened
    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            mem[index] <= wdata;
        end
    end

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ADDR_BITS = 6
) (
    input  logic                 clk,

    // port a, cpu hits
    input  logic                 a_en,
    input  logic [ADDR_BITS-1:0] a_addr,
    input  dcache_pkg::strobe_t  a_wstrb,
    input  dcache_pkg::word_t    a_wdata,
    output dcache_pkg::word_t    a_rdata,

    // port b, refill and victim readout
    input  logic [ADDR_BITS-1:0] b_addr,
    input  logic                 b_wen,
    input  dcache_pkg::word_t    b_wdata,
    output dcache_pkg::word_t    b_rdata
);
    import dcache_pkg::*;

    localparam int DEPTH = 2**ADDR_BITS;

    word_t mem [DEPTH];

    // both ports read-first
    // the two ports never touch the same word in one cycle
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];
            for (int i = 0; i < DATA_BYTES; i++) begin
                if (a_wstrb[i]) begin
                    mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
                end
            end
        end

        // old word comes out while the new one goes in
        b_rdata <= mem[b_addr];
        if (b_wen) begin
            mem[b_addr] <= b_wdata;
        end
    end

endmodule

// File: source/tag_lookup.sv
`timescale 1ns/1ps

module tag_lookup #(
    parameter int WAY_BITS    = 2,
    parameter int INDEX_BITS  = 2,
    parameter int OFFSET_BITS = 2
) (
    input  logic                                    clk,
    input  logic                                    resetn,

    input  logic                                    req,
    input  logic                                    is_write,
    input  dcache_pkg::addr_t                       addr,
    input  dcache_pkg::strobe_t                     wstrb,
    input  dcache_pkg::word_t                       wdata,
    output logic                                    addr_ok,

    output logic                                    a_en,
    output logic [WAY_BITS+INDEX_BITS+OFFSET_BITS-1:0] a_addr,
    output dcache_pkg::strobe_t                     a_wstrb,
    output dcache_pkg::word_t                       a_wdata,

    refill_if.lookup                                rf
);
    import dcache_pkg::*;

    localparam int NUM_WAYS = 2**WAY_BITS;
    localparam int TAG_BITS = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

    typedef logic [WAY_BITS-1:0] way_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef struct packed {
        logic valid;
        logic dirty;
    } record_t;
    typedef tag_t    [NUM_WAYS-1:0] tags_t;
    typedef record_t [NUM_WAYS-1:0] records_t;
    typedef logic    [NUM_WAYS-2:0] plru_t;

    // tree walk, each node bit points at the side to evict
    function automatic way_t plru_victim(plru_t sel);
        int   node;
        way_t way;
        node = 0;
        way  = '0;
        for (int l = 0; l < WAY_BITS; l++) begin
            way[WAY_BITS-1-l] = sel[node];
            node = 2 * node + 1 + int'(sel[node]);
        end
        return way;
    endfunction

    // make the touched way most recent: nodes on its path point away
    function automatic plru_t plru_touch(plru_t sel, way_t way);
        int    node;
        plru_t nxt;
        node = 0;
        nxt  = sel;
        for (int l = 0; l < WAY_BITS; l++) begin
            nxt[node] = ~way[WAY_BITS-1-l];
            node = 2 * node + 1 + int'(way[WAY_BITS-1-l]);
        end
        return nxt;
    endfunction

    tag_t                   req_tag;
    logic [INDEX_BITS-1:0]  req_index;
    logic [OFFSET_BITS-1:0] req_offset;

    assign req_tag    = addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign req_index  = addr[ALIGN_BITS+OFFSET_BITS +: INDEX_BITS];
    assign req_offset = addr[ALIGN_BITS +: OFFSET_BITS];

    tags_t    tags, new_tags;
    records_t records, new_records;
    plru_t    plru, new_plru;

    set_ram #(.INDEX_BITS(INDEX_BITS), .payload_t(tags_t)) tag_ram_i (
        .clk(clk), .resetn(resetn), .index(req_index), .wdata(new_tags), .rdata(tags)
    );
    set_ram #(.INDEX_BITS(INDEX_BITS), .payload_t(records_t)) record_ram_i (
        .clk(clk), .resetn(resetn), .index(req_index), .wdata(new_records), .rdata(records)
    );
    set_ram #(.INDEX_BITS(INDEX_BITS), .payload_t(plru_t)) plru_ram_i (
        .clk(clk), .resetn(resetn), .index(req_index), .wdata(new_plru), .rdata(plru)
    );

    // all ways compared at once
    logic [NUM_WAYS-1:0] hit_bits;
    logic                hit;
    way_t                hit_way;
    way_t                victim_way;

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_cmp
        assign hit_bits[i] = records[i].valid && tags[i] == req_tag;
    end

    assign hit = |hit_bits;

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (hit_bits[i]) begin
                hit_way = way_t'(i);
            end
        end
    end

    assign victim_way = plru_victim(plru);

    // early restart: a word of the line in flight waits for its beat
    logic in_refill;
    logic word_ok;
    logic to_hit;
    logic to_miss;

    assign in_refill = rf.busy && rf.cur_tag == req_tag && rf.cur_index == req_index;
    assign word_ok   = !in_refill || rf.word_ready[req_offset];
    assign addr_ok   = hit && word_ok;
    assign to_hit    = req && addr_ok;
    assign to_miss   = req && !hit && rf.avail;

    assign a_en    = to_hit;
    assign a_addr  = {hit_way, req_index, req_offset};
    assign a_wstrb = is_write ? wstrb : '0;
    assign a_wdata = wdata;

    // victim details go out with the start pulse
    assign rf.start        = to_miss;
    assign rf.miss_addr    = addr;
    assign rf.victim_way   = victim_way;
    assign rf.victim_tag   = tags[victim_way];
    assign rf.victim_dirty = records[victim_way].valid && records[victim_way].dirty;

    always_comb begin
        new_tags    = tags;
        new_records = records;
        new_plru    = plru;
        if (to_hit) begin
            new_plru = plru_touch(plru, hit_way);
            if (is_write) begin
                new_records[hit_way].dirty = 1'b1;
            end
        end else if (to_miss) begin
            // line claimed now, words become usable as they arrive
            new_tags[victim_way]          = req_tag;
            new_records[victim_way].valid = 1'b1;
            new_records[victim_way].dirty = 1'b0;
        end
    end

endmodule

// File: source/line_refill.sv
`timescale 1ns/1ps

module line_refill #(
    parameter int WAY_BITS    = 2,
    parameter int INDEX_BITS  = 2,
    parameter int OFFSET_BITS = 2
) (
    input  logic                                       clk,
    input  logic                                       resetn,

    refill_if.refill                                   rf,

    output logic [WAY_BITS+INDEX_BITS+OFFSET_BITS-1:0] b_addr,
    output logic                                       b_wen,
    output dcache_pkg::word_t                          b_wdata,
    input  dcache_pkg::word_t                          b_rdata,

    output logic                                       cbus_valid,
    output logic                                       cbus_is_write,
    output dcache_pkg::addr_t                          cbus_addr,
    output dcache_pkg::word_t                          cbus_wdata,
    input  logic                                       cbus_okay,
    input  logic                                       cbus_last,
    input  dcache_pkg::word_t                          cbus_rdata
);
    import dcache_pkg::*;

    localparam int NUM_WORDS = 2**OFFSET_BITS;
    localparam int TAG_BITS  = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

    typedef logic [OFFSET_BITS-1:0] offset_t;

    refill_state_t          state;
    addr_t                  miss_addr;
    logic [WAY_BITS-1:0]    fill_way;
    offset_t                pos_offset;
    logic [NUM_WORDS-1:0]   ready;

    // victim line, filled one cycle behind the read beats
    logic [TAG_BITS-1:0]    vtag;
    logic                   vdirty;
    logic                   vwrten;
    offset_t                voffset;
    word_t                  victim [NUM_WORDS];

    logic [INDEX_BITS-1:0]  fill_index;
    logic                   beat;
    logic                   final_beat;

    assign fill_index = miss_addr[ALIGN_BITS+OFFSET_BITS +: INDEX_BITS];
    assign beat       = cbus_okay;
    assign final_beat = cbus_okay && cbus_last;

    // progress seen by lookup
    assign rf.busy       = state != IDLE;
    assign rf.avail      = state == IDLE || (state == WRITE && final_beat);
    assign rf.cur_tag    = miss_addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign rf.cur_index  = fill_index;
    assign rf.word_ready = ready;

    // refill writes the arriving word into the claimed way
    assign b_addr  = {fill_way, fill_index, pos_offset};
    assign b_wen   = state == READ && beat;
    assign b_wdata = cbus_rdata;

    assign cbus_valid    = state != IDLE;
    assign cbus_is_write = state == WRITE;
    assign cbus_addr     = miss_addr;
    assign cbus_wdata    = victim[pos_offset];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state  <= IDLE;
            vwrten <= 1'b0;
            ready  <= '0;
        end else begin
            vwrten <= 1'b0;

            case (state)
                READ: begin
                    // port b hands back the old word next cycle
                    vwrten  <= beat;
                    voffset <= pos_offset;
                    if (beat) begin
                        pos_offset        <= pos_offset + 1'b1;
                        ready[pos_offset] <= 1'b1;
                    end
                    if (final_beat) begin
                        state <= vdirty ? WRITE : IDLE;
                        // writeback goes to the old line, same start word
                        miss_addr[ADDR_WIDTH-1 -: TAG_BITS] <= vtag;
                    end
                end

                WRITE: begin
                    if (beat) begin
                        pos_offset <= pos_offset + 1'b1;
                    end
                    if (final_beat) begin
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase

            // a new miss overrides the last writeback beat
            if (rf.start) begin
                state      <= READ;
                miss_addr  <= rf.miss_addr & ~addr_t'(DATA_BYTES - 1);
                fill_way   <= rf.victim_way;
                pos_offset <= rf.miss_addr[ALIGN_BITS +: OFFSET_BITS];
                ready      <= '0;
                vtag       <= rf.victim_tag;
                vdirty     <= rf.victim_dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vwrten) begin
            victim[voffset] <= b_rdata;
        end
    end

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int WAY_BITS    = 2,
    parameter int INDEX_BITS  = 2,
    parameter int OFFSET_BITS = 2
) (
    input  logic                clk,
    input  logic                resetn,

    // dbus
    input  logic                req,
    input  logic                is_write,
    input  dcache_pkg::addr_t   addr,
    input  dcache_pkg::strobe_t wstrb,
    input  dcache_pkg::word_t   wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,

    // cbus
    output logic                cbus_valid,
    output logic                cbus_is_write,
    output dcache_pkg::addr_t   cbus_addr,
    output dcache_pkg::word_t   cbus_wdata,
    input  logic                cbus_okay,
    input  logic                cbus_last,
    input  dcache_pkg::word_t   cbus_rdata
);
    import dcache_pkg::*;

    localparam int RAM_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS;

    logic                a_en;
    logic [RAM_BITS-1:0] a_addr;
    strobe_t             a_wstrb;
    word_t               a_wdata;
    word_t               a_rdata;

    logic [RAM_BITS-1:0] b_addr;
    logic                b_wen;
    word_t               b_wdata;
    word_t               b_rdata;

    refill_if #(
        .WAY_BITS(WAY_BITS), .INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)
    ) rf_i ();

    tag_lookup #(
        .WAY_BITS(WAY_BITS), .INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)
    ) lookup_i (
        .clk(clk), .resetn(resetn),
        .req(req), .is_write(is_write), .addr(addr), .wstrb(wstrb), .wdata(wdata),
        .addr_ok(addr_ok),
        .a_en(a_en), .a_addr(a_addr), .a_wstrb(a_wstrb), .a_wdata(a_wdata),
        .rf(rf_i.lookup)
    );

    line_refill #(
        .WAY_BITS(WAY_BITS), .INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)
    ) refill_i (
        .clk(clk), .resetn(resetn),
        .rf(rf_i.refill),
        .b_addr(b_addr), .b_wen(b_wen), .b_wdata(b_wdata), .b_rdata(b_rdata),
        .cbus_valid(cbus_valid), .cbus_is_write(cbus_is_write),
        .cbus_addr(cbus_addr), .cbus_wdata(cbus_wdata),
        .cbus_okay(cbus_okay), .cbus_last(cbus_last), .cbus_rdata(cbus_rdata)
    );

    data_ram #(.ADDR_BITS(RAM_BITS)) data_ram_i (
        .clk(clk),
        .a_en(a_en), .a_addr(a_addr), .a_wstrb(a_wstrb),
        .a_wdata(a_wdata), .a_rdata(a_rdata),
        .b_addr(b_addr), .b_wen(b_wen), .b_wdata(b_wdata), .b_rdata(b_rdata)
    );

    // response follows the accepted cycle, word comes from port a
    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= a_en;
        end
    end

    assign rdata = a_rdata;

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic resetn
);
    // resetn is active high in this design
    initial begin
        clk    = 1'b0;
        resetn = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: verification/bus_memory.sv
`timescale 1ns/1ps

module bus_memory #(
    parameter int MEM_BITS  = 12,
    parameter int LINE_BITS = 2
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              okay_en,
    input  logic              cbus_valid,
    input  logic              cbus_is_write,
    input  dcache_pkg::addr_t cbus_addr,
    input  dcache_pkg::word_t cbus_wdata,
    output logic              cbus_okay,
    output logic              cbus_last,
    output dcache_pkg::word_t cbus_rdata,
    output logic              read_first
);
    import dcache_pkg::*;

    localparam int WORDS = 2**MEM_BITS;

    word_t                mem [WORDS];
    logic [LINE_BITS-1:0] beat_count;
    logic [LINE_BITS-1:0] beat_offset;
    logic [MEM_BITS-1:0]  word_index;

    // every word starts as its own word address xor a marker
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = i ^ 32'hA5A50000;
        end
    end

    // burst wraps inside the line from the requested word
    assign beat_offset = cbus_addr[ALIGN_BITS +: LINE_BITS] + beat_count;
    assign word_index  = {cbus_addr[ALIGN_BITS+LINE_BITS +: MEM_BITS-LINE_BITS], beat_offset};

    assign cbus_okay  = cbus_valid && okay_en;
    assign cbus_last  = beat_count == '1;
    assign cbus_rdata = mem[word_index];
    assign read_first = cbus_okay && !cbus_is_write && beat_count == '0;

    always @(posedge clk) begin
        if (resetn || !cbus_valid) begin
            beat_count <= '0;
        end else if (cbus_okay) begin
            beat_count <= beat_count + 1'b1;
            if (cbus_is_write) begin
                mem[word_index] <= cbus_wdata;
            end
        end
    end

endmodule

// File: verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_TESTS      = 21;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 400 + 16;

    logic    clk;
    logic    resetn;
    logic    req;
    logic    is_write;
    addr_t   addr;
    strobe_t wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    cbus_valid;
    logic    cbus_is_write;
    addr_t   cbus_addr;
    word_t   cbus_wdata;
    logic    cbus_okay;
    logic    cbus_last;
    word_t   cbus_rdata;
    logic    okay_en;
    logic    read_first;

    logic [31:0] lfsr;
    int          read_bursts;
    int          cycle_count;

    // stimulus table and the reference memory behind it
    string   test_name [NUM_TESTS];
    logic    test_write [NUM_TESTS];
    addr_t   test_addr [NUM_TESTS];
    strobe_t test_strb [NUM_TESTS];
    word_t   test_wdata [NUM_TESTS];
    word_t   test_rdata [NUM_TESTS];
    logic    test_refill [NUM_TESTS];
    int      table_len;
    word_t   model_mem [addr_t];

    tb_clock #(.PERIOD(4), .RESET_CYCLES(8)) clock_i (.clk(clk), .resetn(resetn));

    bus_memory memory_i (
        .clk(clk), .resetn(resetn), .okay_en(okay_en),
        .cbus_valid(cbus_valid), .cbus_is_write(cbus_is_write),
        .cbus_addr(cbus_addr), .cbus_wdata(cbus_wdata),
        .cbus_okay(cbus_okay), .cbus_last(cbus_last), .cbus_rdata(cbus_rdata),
        .read_first(read_first)
    );

    dcache_top #(.WAY_BITS(2), .INDEX_BITS(2), .OFFSET_BITS(2)) dut_i (
        .clk(clk), .resetn(resetn),
        .req(req), .is_write(is_write), .addr(addr), .wstrb(wstrb), .wdata(wdata),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .cbus_valid(cbus_valid), .cbus_is_write(cbus_is_write),
        .cbus_addr(cbus_addr), .cbus_wdata(cbus_wdata),
        .cbus_okay(cbus_okay), .cbus_last(cbus_last), .cbus_rdata(cbus_rdata)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t model_read(input addr_t a);
        if (model_mem.exists(a >> 2)) begin
            return model_mem[a >> 2];
        end
        return (a >> 2) ^ 32'hA5A50000;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t nw, input strobe_t s);
        word_t res;
        res = old;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (s[i]) begin
                res[8*i +: 8] = nw[8*i +: 8];
            end
        end
        return res;
    endfunction

    // expected rdata is the word before the access
    // writes update the model
    task automatic add_entry(input string name, input logic wr, input addr_t a,
                             input strobe_t s, input word_t wd, input logic refill);
        word_t old;
        old = model_read(a);
        test_name[table_len]   = name;
        test_write[table_len]  = wr;
        test_addr[table_len]   = a;
        test_strb[table_len]   = s;
        test_wdata[table_len]  = wd;
        test_rdata[table_len]  = old;
        test_refill[table_len] = refill;
        if (wr) begin
            model_mem[a >> 2] = merge_bytes(old, wd, s);
        end
        table_len++;
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
            $display("Test FAILED");
            $fatal(1, "wrong value from the cache");
        end
    endtask

    task automatic run_entry(input int i);
        int bursts_before;
        @(posedge clk);
        req      <= 1'b1;
        is_write <= test_write[i];
        addr     <= test_addr[i];
        wstrb    <= test_strb[i];
        wdata    <= test_wdata[i];
        bursts_before = read_bursts;
        @(negedge clk);
        while (addr_ok !== 1'b1) @(negedge clk);
        @(posedge clk);
        req      <= 1'b0;
        is_write <= 1'b0;
        wstrb    <= '0;
        @(negedge clk);
        check_value(test_name[i], "data_ok", 32'd1, {31'b0, data_ok});
        check_value(test_name[i], "rdata", test_rdata[i], rdata);
        check_value(test_name[i], "read bursts", {31'b0, test_refill[i]},
                    read_bursts - bursts_before);
    endtask

    initial begin
        lfsr        = 32'h9148;
        okay_en     = 1'b0;
        read_bursts = 0;
    end

    // one lfsr bit per cycle gates okay
    always @(posedge clk) begin
        okay_en <= lfsr[31];
        lfsr    <= lfsr_step(lfsr);
        if (read_first) begin
            read_bursts <= read_bursts + 1;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the cache stopped responding after %0d cycles", cycle_count);
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        req       = 1'b0;
        is_write  = 1'b0;
        addr      = '0;
        wstrb     = '0;
        wdata     = '0;
        table_len = 0;

        // cold miss with early restart and then the rest of the line
        add_entry("cold_read",      1'b0, 32'h008, 4'h0, 32'h0, 1'b1);
        add_entry("refill_pending", 1'b0, 32'h004, 4'h0, 32'h0, 1'b0);
        add_entry("line_hit_w0",    1'b0, 32'h000, 4'h0, 32'h0, 1'b0);
        add_entry("line_hit_w3",    1'b0, 32'h00C, 4'h0, 32'h0, 1'b0);
        add_entry("write_partial",  1'b1, 32'h00C, 4'h5, 32'h11223344, 1'b0);
        add_entry("read_merged",    1'b0, 32'h00C, 4'h0, 32'h0, 1'b0);
        // fill set 0
        // the fifth tag evicts the dirty line in way 0
        add_entry("fill_b",         1'b0, 32'h040, 4'h0, 32'h0, 1'b1);
        add_entry("fill_c",         1'b0, 32'h080, 4'h0, 32'h0, 1'b1);
        add_entry("fill_d",         1'b0, 32'h0C0, 4'h0, 32'h0, 1'b1);
        add_entry("evict_dirty",    1'b0, 32'h100, 4'h0, 32'h0, 1'b1);
        // touch c, d and e so the tree names way 2 (line b)
        add_entry("touch_c",        1'b0, 32'h084, 4'h0, 32'h0, 1'b0);
        add_entry("touch_d",        1'b0, 32'h0C4, 4'h0, 32'h0, 1'b0);
        add_entry("touch_e",        1'b0, 32'h104, 4'h0, 32'h0, 1'b0);
        add_entry("refetch_dirty",  1'b0, 32'h00C, 4'h0, 32'h0, 1'b1);
        add_entry("refetch_other",  1'b0, 32'h008, 4'h0, 32'h0, 1'b0);
        // c, d and e survived while b was the evicted line
        add_entry("plru_keep_c",    1'b0, 32'h080, 4'h0, 32'h0, 1'b0);
        add_entry("plru_keep_d",    1'b0, 32'h0C0, 4'h0, 32'h0, 1'b0);
        add_entry("plru_keep_e",    1'b0, 32'h100, 4'h0, 32'h0, 1'b0);
        add_entry("plru_evicted",   1'b0, 32'h040, 4'h0, 32'h0, 1'b1);
        // write allocate in set 1
        add_entry("write_miss",     1'b1, 32'h014, 4'hF, 32'hDEADBEEF, 1'b1);
        add_entry("read_write_miss", 1'b0, 32'h014, 4'h0, 32'h0, 1'b0);

        // reset is high at the first edge, wait for its release
        @(posedge clk);
        while (resetn !== 1'b0) begin
            @(posedge clk);
        end
        for (int i = 0; i < table_len; i++) begin
            run_entry(i);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: tb.f
source/dcache_pkg.sv
source/refill_if.sv
source/set_ram.sv
source/data_ram.sv
source/tag_lookup.sv
source/line_refill.sv
source/dcache_top.sv
verification/tb_clock.sv
verification/bus_memory.sv
verification/dcache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module dcache_tb -f tb.f -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
